// File: tsc_core.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/control_unit.sv
rtl/alu.sv
rtl/register_file.sv
rtl/hazard_unit.sv
rtl/tsc_core.sv
testbench/tsc_core_assertions.sv
testbench/tsc_core_tb.sv

// File: Bender.yml
package:
  name: tsc_core

sources:
  - rtl/isa_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/control_unit.sv
  - rtl/alu.sv
  - rtl/register_file.sv
  - rtl/hazard_unit.sv
  - rtl/tsc_core.sv
  - target: test
    files:
      - testbench/tsc_core_assertions.sv
      - testbench/tsc_core_tb.sv

// File: testbench/tsc_core_tb.sv
`default_nettype none

module tsc_core_tb;

	localparam int RESET_CYCLES = 4;
	localparam isa_pkg::word_t START_PC = 16'h0000;
	localparam logic [11:0] SUB_ADDR = 12'd32; // called by JAL
	localparam logic [7:0] JRL_ADDR = 8'd40;   // called by JRL

	typedef isa_pkg::word_t word_q_t [$];

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	isa_pkg::word_t i_address, i_data, d_address, d_wdata, d_rdata, output_port;
	logic d_read, d_write, wwd, halt;

	isa_pkg::word_t imem [256];
	isa_pkg::word_t dmem [256];
	logic [15:0] lfsr = 16'd81;
	word_q_t expected_q;
	int emit_addr, emit_total, wwd_count;
	int error_count = 0;
	int check_total = 0;
	int test_count = 0;
	int test_errors, cycle_count, cycle_limit;
	string test_name;

	always #10 clk = ~clk;

	tsc_core #(.RESET_PC(START_PC)) tsc_core_i (
		.clk(clk), .rst_n(rst_n),
		.i_address(i_address), .i_data(i_data),
		.d_address(d_address), .d_wdata(d_wdata), .d_rdata(d_rdata),
		.d_read(d_read), .d_write(d_write),
		.output_port(output_port), .wwd(wwd), .halt(halt)
	);

	bind tsc_core tsc_core_assertions tsc_core_assertions_i (
		.clk(clk), .rst_n(rst_n), .wwd(wwd),
		.d_read(d_read), .d_write(d_write), .halt(halt)
	);

	// both memories read combinationally
	assign i_data = imem[i_address[7:0]];
	assign d_rdata = d_read ? dmem[d_address[7:0]] : '0; // data only during a load

	always @(posedge clk) begin
		if (d_write)
			dmem[d_address[7:0]] <= d_wdata;
	end

	// galois lfsr, one step per bit
	function automatic logic [15:0] random_bits(int width);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return value;
	endfunction

	function automatic logic [7:0] random_byte();
		logic [15:0] value;
		value = random_bits(8);
		return value[7:0];
	endfunction

	function automatic isa_pkg::word_t r_word(isa_pkg::func_t func, isa_pkg::reg_idx_t rs,
		isa_pkg::reg_idx_t rt, isa_pkg::reg_idx_t rd);
		return {isa_pkg::ALU_OP, rs, rt, rd, func};
	endfunction

	function automatic isa_pkg::word_t i_word(isa_pkg::opcode_t op, isa_pkg::reg_idx_t rs,
		isa_pkg::reg_idx_t rt, logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isa_pkg::word_t j_word(isa_pkg::opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	task automatic emit(isa_pkg::word_t w);
		imem[emit_addr[7:0]] = w;
		emit_addr++;
		emit_total++;
	endtask

	task automatic show_reg(isa_pkg::reg_idx_t r);
		emit(r_word(isa_pkg::INST_FUNC_WWD, r, 2'd0, 2'd0));
	endtask

	task automatic halt_here();
		emit(r_word(isa_pkg::INST_FUNC_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	task automatic load_const(isa_pkg::reg_idx_t r, isa_pkg::word_t value);
		emit(i_word(isa_pkg::LHI_OP, 2'd0, r, value[15:8]));
		emit(i_word(isa_pkg::ORI_OP, r, r, value[7:0]));
	endtask

	task automatic clear_memories();
		for (int a = 0; a < 256; a++) begin
			imem[a] = {4'hb, 4'h0, a[7:0]}; // undecodable word, runs as a bubble
			dmem[a] = {a[7:0] ^ 8'h5a, a[7:0]};
		end
		emit_addr = 0;
		emit_total = 0;
	endtask

	// plain ISA interpreter, one instruction per step
	function automatic word_q_t reference_run(output logic stopped);
		isa_pkg::word_t regs [4];
		isa_pkg::word_t mem [256];
		isa_pkg::instr_t ins;
		isa_pkg::word_t pc, next_pc, a, b, simm, addr;
		word_q_t outs;
		for (int r = 0; r < 4; r++)
			regs[r] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = dmem[i];
		pc = START_PC;
		stopped = 1'b0;
		for (int step = 0; step < 4096 && !stopped; step++) begin
			ins = imem[pc[7:0]];
			a = regs[ins.r_fmt.rs];
			b = regs[ins.r_fmt.rt];
			simm = {{8{ins.i_fmt.imm[7]}}, ins.i_fmt.imm};
			addr = a + simm;
			next_pc = pc + 16'd1;
			case (ins.r_fmt.opcode)
				isa_pkg::BNE_OP: if (a != b) next_pc = pc + 16'd1 + simm;
				isa_pkg::BEQ_OP: if (a == b) next_pc = pc + 16'd1 + simm;
				isa_pkg::BGZ_OP: if ($signed(a) > 16'sd0) next_pc = pc + 16'd1 + simm;
				isa_pkg::BLZ_OP: if ($signed(a) < 16'sd0) next_pc = pc + 16'd1 + simm;
				isa_pkg::ADI_OP: regs[ins.i_fmt.rt] = a + simm;
				isa_pkg::ORI_OP: regs[ins.i_fmt.rt] = a | {8'h00, ins.i_fmt.imm};
				isa_pkg::LHI_OP: regs[ins.i_fmt.rt] = {ins.i_fmt.imm, 8'h00};
				isa_pkg::LWD_OP: regs[ins.i_fmt.rt] = mem[addr[7:0]];
				isa_pkg::SWD_OP: mem[addr[7:0]] = b;
				isa_pkg::JMP_OP: next_pc = {pc[15:12], ins.j_fmt.target};
				isa_pkg::JAL_OP: begin
					regs[isa_pkg::LINK_REG] = pc + 16'd1;
					next_pc = {pc[15:12], ins.j_fmt.target};
				end
				isa_pkg::ALU_OP: begin
					case (ins.r_fmt.func)
						isa_pkg::INST_FUNC_ADD: regs[ins.r_fmt.rd] = a + b;
						isa_pkg::INST_FUNC_SUB: regs[ins.r_fmt.rd] = a - b;
						isa_pkg::INST_FUNC_AND: regs[ins.r_fmt.rd] = a & b;
						isa_pkg::INST_FUNC_ORR: regs[ins.r_fmt.rd] = a | b;
						isa_pkg::INST_FUNC_NOT: regs[ins.r_fmt.rd] = ~a;
						isa_pkg::INST_FUNC_TCP: regs[ins.r_fmt.rd] = -a;
						isa_pkg::INST_FUNC_SHL: regs[ins.r_fmt.rd] = a << 1;
						isa_pkg::INST_FUNC_SHR: regs[ins.r_fmt.rd] = $signed(a) >>> 1;
						isa_pkg::INST_FUNC_JPR: next_pc = a;
						isa_pkg::INST_FUNC_JRL: begin
							regs[isa_pkg::LINK_REG] = pc + 16'd1;
							next_pc = a; // old rs, read before the link write
						end
						isa_pkg::INST_FUNC_WWD: outs.push_back(a);
						isa_pkg::INST_FUNC_HLT: stopped = 1'b1;
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = next_pc;
		end
		return outs;
	endfunction

	task automatic check_word(isa_pkg::word_t actual, isa_pkg::word_t expected, string what);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_halt(logic actual, logic expected);
		check_total++;
		if (actual !== expected) begin
			error_count++;
			$display("Test %s: halt is %b at the end but the program should give %b",
				test_name, actual, expected);
		end
	endtask

	task automatic check_count(int actual, int expected);
		check_total++;
		if (actual != expected) begin
			error_count++;
			$display("Fail at %0t: %s gave %0d wwd strobes, expected %0d",
				$time, test_name, actual, expected);
		end
	endtask

	// compares each wwd value in program order
	always @(negedge clk) begin
		if (wwd) begin
			if (wwd_count < expected_q.size()) begin
				check_word(output_port, expected_q[wwd_count],
					$sformatf("%s output %0d", test_name, wwd_count));
			end else begin
				error_count++;
				$display("Test %s: an extra wwd strobe showed %h after the expected outputs",
					test_name, output_port);
			end
			wwd_count++;
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count <= cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the core did not halt within %0d cycles", cycle_limit);
		$display("Errors found");
		$finish;
	end

	task automatic start_test(string name);
		test_name = name;
		test_errors = error_count;
		cycle_limit += RESET_CYCLES + 8;
		@(negedge clk);
		rst_n = 1'b0;
		clear_memories();
	endtask

	task automatic run_test();
		logic ref_halt;
		expected_q = reference_run(ref_halt);
		wwd_count = 0;
		cycle_limit += 8 * emit_total;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		while (!halt) @(negedge clk);
		repeat (4) @(negedge clk); // a late strobe would land here
		check_halt(halt, ref_halt);
		check_count(wwd_count, expected_q.size());
		test_count++;
		if (error_count == test_errors)
			$display("test %0d %s: ok, %0d outputs", test_count, test_name, wwd_count);
		else
			$display("test %0d %s: %0d errors", test_count, test_name, error_count - test_errors);
	endtask

	task automatic alu_program();
		isa_pkg::word_t v;
		start_test("alu");
		load_const(2'd0, random_bits(16));
		v = random_bits(16);
		v[15] = 1'b1; // negative, for the arithmetic shift
		load_const(2'd1, v);
		for (int f = 0; f < 8; f++) begin
			emit(r_word(f[5:0], 2'd0, 2'd1, 2'd3));
			show_reg(2'd3);
		end
		emit(r_word(isa_pkg::INST_FUNC_SHR, 2'd1, 2'd0, 2'd2));
		show_reg(2'd2);
		halt_here();
		run_test();
	endtask

	task automatic immediate_program();
		logic [7:0] imm;
		start_test("immediate");
		load_const(2'd0, random_bits(16));
		imm = random_byte() | 8'h80;
		emit(i_word(isa_pkg::ADI_OP, 2'd0, 2'd1, imm));
		show_reg(2'd1);
		emit(i_word(isa_pkg::ADI_OP, 2'd1, 2'd1, 8'h80)); // -128
		show_reg(2'd1);
		emit(i_word(isa_pkg::ORI_OP, 2'd0, 2'd2, imm));
		show_reg(2'd2);
		emit(i_word(isa_pkg::ORI_OP, 2'd3, 2'd3, 8'hff));
		show_reg(2'd3);
		emit(i_word(isa_pkg::LHI_OP, 2'd0, 2'd3, random_byte()));
		show_reg(2'd3);
		halt_here();
		run_test();
	endtask

	task automatic memory_program();
		logic [7:0] off;
		start_test("memory");
		load_const(2'd0, random_bits(16)); // base
		load_const(2'd1, random_bits(16));
		load_const(2'd2, random_bits(16));
		off = random_byte();
		emit(i_word(isa_pkg::SWD_OP, 2'd0, 2'd1, off));
		emit(i_word(isa_pkg::SWD_OP, 2'd0, 2'd2, off ^ 8'h01));
		emit(i_word(isa_pkg::LWD_OP, 2'd0, 2'd3, off));
		show_reg(2'd3);
		emit(i_word(isa_pkg::LWD_OP, 2'd0, 2'd3, off ^ 8'h01));
		show_reg(2'd3);
		emit(i_word(isa_pkg::LWD_OP, 2'd0, 2'd1, off ^ 8'h80)); // untouched word
		show_reg(2'd1);
		halt_here();
		run_test();
	endtask

	task automatic branch_case(isa_pkg::opcode_t op, isa_pkg::reg_idx_t rs,
		isa_pkg::reg_idx_t rt, int skip);
		emit(i_word(op, rs, rt, skip[7:0]));
		for (int i = 0; i < skip; i++)
			show_reg(2'd2); // squashed when taken
		show_reg(2'd3);
		emit(i_word(isa_pkg::ADI_OP, 2'd3, 2'd3, 8'd1)); // next marker
	endtask

	task automatic branch_program();
		isa_pkg::word_t v;
		start_test("branch");
		v = random_bits(16);
		v[15] = 1'b0;
		v[0] = 1'b1; // strictly positive
		load_const(2'd0, v);
		v = random_bits(16);
		v[15] = 1'b1;
		load_const(2'd1, v);
		load_const(2'd2, 16'hdead);
		load_const(2'd3, 16'h0100);
		branch_case(isa_pkg::BNE_OP, 2'd0, 2'd1, 1);
		branch_case(isa_pkg::BNE_OP, 2'd0, 2'd0, 2);
		branch_case(isa_pkg::BEQ_OP, 2'd1, 2'd1, 2);
		branch_case(isa_pkg::BEQ_OP, 2'd0, 2'd1, 1);
		branch_case(isa_pkg::BGZ_OP, 2'd0, 2'd0, 1);
		branch_case(isa_pkg::BGZ_OP, 2'd1, 2'd0, 2);
		branch_case(isa_pkg::BLZ_OP, 2'd1, 2'd0, 2);
		branch_case(isa_pkg::BLZ_OP, 2'd0, 2'd0, 1);
		halt_here();
		run_test();
	endtask

	task automatic jump_program();
		start_test("jump");
		emit(i_word(isa_pkg::LHI_OP, 2'd0, 2'd3, random_byte()));
		emit(j_word(isa_pkg::JMP_OP, 12'd3));
		show_reg(2'd3); // jumped over
		emit(j_word(isa_pkg::JAL_OP, SUB_ADDR));
		show_reg(2'd2);
		load_const(2'd0, {8'h00, JRL_ADDR});
		emit(r_word(isa_pkg::INST_FUNC_JRL, 2'd0, 2'd0, 2'd0));
		show_reg(2'd2);
		halt_here();
		emit_addr = int'(SUB_ADDR);
		show_reg(2'd3);
		emit(r_word(isa_pkg::INST_FUNC_JPR, 2'd2, 2'd0, 2'd0));
		show_reg(2'd3);
		emit_addr = int'(JRL_ADDR);
		show_reg(2'd2);
		emit(i_word(isa_pkg::ADI_OP, 2'd3, 2'd3, 8'd1));
		show_reg(2'd3);
		emit(r_word(isa_pkg::INST_FUNC_JPR, 2'd2, 2'd0, 2'd0));
		run_test();
	endtask

	task automatic hazard_program();
		start_test("hazard");
		load_const(2'd0, random_bits(16));
		emit(r_word(isa_pkg::INST_FUNC_ADD, 2'd0, 2'd0, 2'd1));
		emit(r_word(isa_pkg::INST_FUNC_SUB, 2'd1, 2'd0, 2'd2));
		show_reg(2'd2);
		emit(i_word(isa_pkg::LHI_OP, 2'd0, 2'd3, 8'h00));
		emit(i_word(isa_pkg::ADI_OP, 2'd3, 2'd3, random_byte()));
		emit(i_word(isa_pkg::SWD_OP, 2'd3, 2'd2, 8'd5));
		emit(i_word(isa_pkg::LWD_OP, 2'd3, 2'd1, 8'd5));
		emit(r_word(isa_pkg::INST_FUNC_ADD, 2'd1, 2'd1, 2'd0)); // load then use
		show_reg(2'd0);
		emit(i_word(isa_pkg::ADI_OP, 2'd0, 2'd0, 8'hfd));
		show_reg(2'd0);
		halt_here();
		show_reg(2'd1); // behind the halt
		show_reg(2'd0);
		run_test();
	endtask

	initial begin
		cycle_limit = 0;
		clear_memories();
		alu_program();
		immediate_program();
		memory_program();
		branch_program();
		jump_program();
		hazard_program();
		error_count += tsc_core_i.tsc_core_assertions_i.failures;
		$display("%0d tests, %0d checks, %0d errors", test_count, check_total, error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tsc_core_assertions.sv
`default_nettype none

module tsc_core_assertions (
	input wire clk,
	input wire rst_n,
	input wire wwd,
	input wire d_read,
	input wire d_write,
	input wire halt
);

	int failures = 0; // read by the testbench at the end

	// core stays quiet while reset is held
	reset_quiet: assert property (@(posedge clk) !rst_n |-> (!wwd && !d_read && !d_write))
		else begin
			failures++;
			$error("wwd or a data memory strobe is active during reset");
		end

	one_access: assert property (@(posedge clk) disable iff (!rst_n) !(d_read && d_write))
		else begin
			failures++;
			$error("d_read and d_write are set in the same cycle");
		end

	// halt is sticky until the next reset
	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
		else begin
			failures++;
			$error("halt dropped without a reset");
		end

endmodule

`default_nettype wire

// File: rtl/tsc_core.sv
`default_nettype none

module tsc_core #(
	parameter isa_pkg::word_t RESET_PC = '0
) (
	input wire clk,
	input wire rst_n,
	output isa_pkg::word_t i_address,
	input wire isa_pkg::word_t i_data,
	output isa_pkg::word_t d_address,
	output isa_pkg::word_t d_wdata,
	input wire isa_pkg::word_t d_rdata,
	output logic d_read,
	output logic d_write,
	output isa_pkg::word_t output_port,
	output logic wwd,
	output logic halt
);

	isa_pkg::word_t pc;
	logic halted;
	isa_pkg::instr_t d_instr;

	// decode outputs in D
	logic c_halt, c_wwd, c_new_inst, c_use_rs, c_use_rt;
	logic c_alu_src, c_branch, c_mem_read, c_mem_write, c_reg_write;
	ctrl_pkg::pc_src_t c_pc_src;
	ctrl_pkg::reg_dest_t c_reg_dest;
	ctrl_pkg::reg_src_t c_reg_src;
	ctrl_pkg::branch_t c_br_type;
	ctrl_pkg::alu_func_t c_alu_func;
	isa_pkg::word_t rs_data, rt_data, d_imm;
	isa_pkg::reg_idx_t d_dest;
	logic stall;

	// E stage state
	logic e_valid, e_halt, e_wwd, e_alu_src, e_branch;
	logic e_mem_read, e_mem_write, e_reg_write;
	ctrl_pkg::pc_src_t e_pc_src;
	ctrl_pkg::reg_src_t e_reg_src;
	ctrl_pkg::branch_t e_br_type;
	ctrl_pkg::alu_func_t e_alu_func;
	isa_pkg::word_t e_pc, e_rs_data, e_rt_data, e_imm;
	isa_pkg::reg_idx_t e_dest;

	isa_pkg::word_t alu_b, alu_result, e_pc1, wb_data, target;
	logic branch_cond, redirect, freeze, load_e;

	assign i_address = pc;
	assign d_instr = i_data;

	control_unit control_unit_i (
		.opcode(d_instr.r_fmt.opcode), .func_code(d_instr.r_fmt.func),
		.halt(c_halt), .wwd(c_wwd), .new_inst(c_new_inst),
		.use_rs(c_use_rs), .use_rt(c_use_rt), .alu_src(c_alu_src), .branch(c_branch),
		.mem_read(c_mem_read), .mem_write(c_mem_write), .reg_write(c_reg_write),
		.pc_src(c_pc_src), .reg_dest(c_reg_dest), .reg_src(c_reg_src),
		.alu_branch_type(c_br_type), .alu_func_code(c_alu_func)
	);

	register_file register_file_i (
		.clk(clk), .rst_n(rst_n),
		.rs(d_instr.r_fmt.rs), .rt(d_instr.r_fmt.rt),
		.rs_data(rs_data), .rt_data(rt_data),
		.we(e_valid & e_reg_write), .wr_idx(e_dest), .wr_data(wb_data)
	);

	hazard_unit hazard_unit_i (
		.rs(d_instr.r_fmt.rs), .rt(d_instr.r_fmt.rt),
		.use_rs(c_use_rs), .use_rt(c_use_rt),
		.e_valid(e_valid), .e_reg_write(e_reg_write), .e_dest(e_dest),
		.stall(stall)
	);

	// immediate, jump target is formed here too
	always_comb begin
		case (d_instr.i_fmt.opcode)
			isa_pkg::ORI_OP: d_imm = {8'h00, d_instr.i_fmt.imm};
			isa_pkg::LHI_OP: d_imm = {d_instr.i_fmt.imm, 8'h00};
			isa_pkg::JMP_OP, isa_pkg::JAL_OP: d_imm = {pc[15:12], d_instr.j_fmt.target};
			default: d_imm = {{8{d_instr.i_fmt.imm[7]}}, d_instr.i_fmt.imm};
		endcase
	end

	always_comb begin
		case (c_reg_dest)
			ctrl_pkg::DEST_RT:   d_dest = d_instr.i_fmt.rt;
			ctrl_pkg::DEST_LINK: d_dest = isa_pkg::LINK_REG;
			default:             d_dest = d_instr.r_fmt.rd;
		endcase
	end

	assign freeze = halted | (e_valid & e_halt);
	assign load_e = c_new_inst & ~stall & ~redirect; // otherwise a bubble

	assign alu_b = e_alu_src ? e_imm : e_rt_data;

	alu alu_i (
		.func(e_alu_func), .branch_type(e_br_type),
		.a(e_rs_data), .b(alu_b),
		.result(alu_result), .branch_cond(branch_cond)
	);

	assign e_pc1 = e_pc + 16'd1;
	assign redirect = e_valid & ((e_branch & branch_cond) |
		(e_pc_src == ctrl_pkg::PC_JUMP) | (e_pc_src == ctrl_pkg::PC_REG));

	always_comb begin
		case (e_pc_src)
			ctrl_pkg::PC_JUMP: target = e_imm;
			ctrl_pkg::PC_REG:  target = alu_result; // rs via ID1
			default:           target = e_pc1 + e_imm;
		endcase
	end

	always_comb begin
		case (e_reg_src)
			ctrl_pkg::SRC_MEM: wb_data = d_rdata;
			ctrl_pkg::SRC_PC:  wb_data = e_pc1; // link value
			default:           wb_data = alu_result;
		endcase
	end

	assign d_address = alu_result;
	assign d_wdata = e_rt_data;
	assign d_read = e_valid & e_mem_read;
	assign d_write = e_valid & e_mem_write;
	assign output_port = e_rs_data;
	assign wwd = e_valid & e_wwd;
	assign halt = freeze;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			halted <= 1'b0;
		end else if (!freeze) begin
			if (redirect)
				pc <= target;
			else if (!stall)
				pc <= pc + 16'd1;
		end else begin
			halted <= 1'b1; // sticky until reset
		end
	end

	// E controls, cleared for a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			{e_valid, e_halt, e_wwd, e_alu_src, e_branch} <= '0;
			{e_mem_read, e_mem_write, e_reg_write} <= '0;
			e_pc_src <= ctrl_pkg::PC_BRANCH;
			e_reg_src <= ctrl_pkg::SRC_ALU;
			e_br_type <= ctrl_pkg::BR_NE;
			e_alu_func <= ctrl_pkg::FUNC_NONE;
		end else if (!freeze) begin
			e_valid <= load_e;
			e_halt <= load_e & c_halt;
			e_wwd <= load_e & c_wwd;
			e_alu_src <= load_e & c_alu_src;
			e_branch <= load_e & c_branch;
			e_mem_read <= load_e & c_mem_read;
			e_mem_write <= load_e & c_mem_write;
			e_reg_write <= load_e & c_reg_write;
			e_pc_src <= load_e ? c_pc_src : ctrl_pkg::PC_BRANCH;
			e_reg_src <= load_e ? c_reg_src : ctrl_pkg::SRC_ALU;
			e_br_type <= load_e ? c_br_type : ctrl_pkg::BR_NE;
			e_alu_func <= load_e ? c_alu_func : ctrl_pkg::FUNC_NONE;
		end
	end

	// operands and immediate
	always_ff @(posedge clk) begin
		if (!freeze && load_e) begin
			e_pc <= pc;
			e_rs_data <= rs_data;
			e_rt_data <= rt_data;
			e_imm <= d_imm;
			e_dest <= d_dest;
		end
	end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input wire isa_pkg::reg_idx_t rs,
	input wire isa_pkg::reg_idx_t rt,
	input wire use_rs,
	input wire use_rt,
	input wire e_valid,
	input wire e_reg_write,
	input wire isa_pkg::reg_idx_t e_dest,
	output logic stall
);

	logic e_pending; // E will write a register at the next edge
	logic rs_hit;
	logic rt_hit;

	assign e_pending = e_valid & e_reg_write;
	assign rs_hit = use_rs & (rs == e_dest);
	assign rt_hit = use_rt & (rt == e_dest);

	// one cycle of stall lets the write land before D reads again
	assign stall = e_pending & (rs_hit | rt_hit);

endmodule

`default_nettype wire

// File: rtl/register_file.sv
`default_nettype none

module register_file (
	input wire clk,
	input wire rst_n,
	input wire isa_pkg::reg_idx_t rs,
	input wire isa_pkg::reg_idx_t rt,
	output isa_pkg::word_t rs_data,
	output isa_pkg::word_t rt_data,
	input wire we,
	input wire isa_pkg::reg_idx_t wr_idx,
	input wire isa_pkg::word_t wr_data
);

	isa_pkg::word_t regs [4];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// reads are combinational, written value visible after the edge
	assign rs_data = regs[rs];
	assign rt_data = regs[rt];

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

module alu (
	input wire ctrl_pkg::alu_func_t func,
	input wire ctrl_pkg::branch_t branch_type,
	input wire isa_pkg::word_t a,
	input wire isa_pkg::word_t b,
	output isa_pkg::word_t result,
	output logic branch_cond
);

	always_comb begin
		result = '0;
		case (func)
			ctrl_pkg::FUNC_ADD: result = a + b;
			ctrl_pkg::FUNC_SUB: result = a - b;
			ctrl_pkg::FUNC_AND: result = a & b;
			ctrl_pkg::FUNC_ORR: result = a | b;
			ctrl_pkg::FUNC_NOT: result = ~a;
			ctrl_pkg::FUNC_TCP: result = ~a + 16'd1; // two's complement negate
			ctrl_pkg::FUNC_SHL: result = {a[14:0], 1'b0};
			ctrl_pkg::FUNC_SHR: result = {a[15], a[15:1]}; // keeps sign
			ctrl_pkg::FUNC_ID1: result = a;
			ctrl_pkg::FUNC_ID2: result = b;
			default: result = '0;
		endcase
	end

	// condition only meaningful for branch compares
	always_comb begin
		branch_cond = 1'b0;
		if (func == ctrl_pkg::FUNC_BXX) begin
			case (branch_type)
				ctrl_pkg::BR_NE: branch_cond = (a != b);
				ctrl_pkg::BR_EQ: branch_cond = (a == b);
				ctrl_pkg::BR_GZ: branch_cond = ~a[15] & (a != '0); // signed > 0
				default:         branch_cond = a[15]; // signed < 0
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
`default_nettype none

module control_unit (
	input wire isa_pkg::opcode_t opcode,
	input wire isa_pkg::func_t func_code,
	output logic halt,
	output logic wwd,
	output logic new_inst,
	output logic use_rs,
	output logic use_rt,
	output logic alu_src,
	output logic branch,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output ctrl_pkg::pc_src_t pc_src,
	output ctrl_pkg::reg_dest_t reg_dest,
	output ctrl_pkg::reg_src_t reg_src,
	output ctrl_pkg::branch_t alu_branch_type,
	output ctrl_pkg::alu_func_t alu_func_code
);

	// datapath controls
	always_comb begin
		halt = 1'b0;
		wwd = 1'b0;
		new_inst = 1'b0;
		use_rs = 1'b0;
		use_rt = 1'b0;
		alu_src = 1'b0;
		branch = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		pc_src = ctrl_pkg::PC_BRANCH;
		reg_dest = ctrl_pkg::DEST_RD;
		reg_src = ctrl_pkg::SRC_ALU;

		case (opcode)
			isa_pkg::ALU_OP: begin
				case (func_code)
					isa_pkg::INST_FUNC_ADD, isa_pkg::INST_FUNC_SUB,
					isa_pkg::INST_FUNC_AND, isa_pkg::INST_FUNC_ORR: begin
						use_rs = 1'b1;
						use_rt = 1'b1;
						reg_write = 1'b1;
						new_inst = 1'b1;
					end
					isa_pkg::INST_FUNC_NOT, isa_pkg::INST_FUNC_TCP,
					isa_pkg::INST_FUNC_SHL, isa_pkg::INST_FUNC_SHR: begin
						use_rs = 1'b1; // unary, rt ignored
						reg_write = 1'b1;
						new_inst = 1'b1;
					end
					isa_pkg::INST_FUNC_JPR: begin
						use_rs = 1'b1;
						pc_src = ctrl_pkg::PC_REG;
						new_inst = 1'b1;
					end
					isa_pkg::INST_FUNC_JRL: begin
						use_rs = 1'b1;
						pc_src = ctrl_pkg::PC_REG;
						reg_dest = ctrl_pkg::DEST_LINK;
						reg_src = ctrl_pkg::SRC_PC; // link = pc+1
						reg_write = 1'b1;
						new_inst = 1'b1;
					end
					isa_pkg::INST_FUNC_WWD: begin
						wwd = 1'b1;
						use_rs = 1'b1;
						new_inst = 1'b1;
					end
					isa_pkg::INST_FUNC_HLT: begin
						halt = 1'b1;
						new_inst = 1'b1;
					end
					default: ;
				endcase
			end
			isa_pkg::ADI_OP, isa_pkg::ORI_OP: begin
				use_rs = 1'b1;
				alu_src = 1'b1;
				reg_dest = ctrl_pkg::DEST_RT;
				reg_write = 1'b1;
				new_inst = 1'b1;
			end
			isa_pkg::LHI_OP: begin
				alu_src = 1'b1;
				reg_dest = ctrl_pkg::DEST_RT;
				reg_write = 1'b1;
				new_inst = 1'b1;
			end
			isa_pkg::LWD_OP: begin
				use_rs = 1'b1;
				alu_src = 1'b1;
				mem_read = 1'b1;
				reg_dest = ctrl_pkg::DEST_RT;
				reg_src = ctrl_pkg::SRC_MEM;
				reg_write = 1'b1;
				new_inst = 1'b1;
			end
			isa_pkg::SWD_OP: begin
				use_rs = 1'b1;
				use_rt = 1'b1; // store data comes from rt
				alu_src = 1'b1;
				mem_write = 1'b1;
				new_inst = 1'b1;
			end
			isa_pkg::BNE_OP, isa_pkg::BEQ_OP: begin
				use_rs = 1'b1;
				use_rt = 1'b1;
				branch = 1'b1;
				new_inst = 1'b1;
			end
			isa_pkg::BGZ_OP, isa_pkg::BLZ_OP: begin
				use_rs = 1'b1; // compare against zero
				branch = 1'b1;
				new_inst = 1'b1;
			end
			isa_pkg::JMP_OP: begin
				pc_src = ctrl_pkg::PC_JUMP;
				new_inst = 1'b1;
			end
			isa_pkg::JAL_OP: begin
				pc_src = ctrl_pkg::PC_JUMP;
				reg_dest = ctrl_pkg::DEST_LINK;
				reg_src = ctrl_pkg::SRC_PC;
				reg_write = 1'b1;
				new_inst = 1'b1;
			end
			default: ;
		endcase
	end

	// alu controls
	always_comb begin
		alu_func_code = ctrl_pkg::FUNC_NONE;
		alu_branch_type = ctrl_pkg::BR_NE;

		case (opcode)
			isa_pkg::ALU_OP: begin
				case (func_code)
					isa_pkg::INST_FUNC_ADD, isa_pkg::INST_FUNC_SUB,
					isa_pkg::INST_FUNC_AND, isa_pkg::INST_FUNC_ORR,
					isa_pkg::INST_FUNC_NOT, isa_pkg::INST_FUNC_TCP,
					isa_pkg::INST_FUNC_SHL, isa_pkg::INST_FUNC_SHR:
						alu_func_code = func_code[3:0]; // same numbering
					isa_pkg::INST_FUNC_JPR, isa_pkg::INST_FUNC_JRL,
					isa_pkg::INST_FUNC_WWD:
						alu_func_code = ctrl_pkg::FUNC_ID1; // rs straight through
					default: ;
				endcase
			end
			isa_pkg::ADI_OP, isa_pkg::LWD_OP, isa_pkg::SWD_OP:
				alu_func_code = ctrl_pkg::FUNC_ADD; // rs + imm
			isa_pkg::ORI_OP: alu_func_code = ctrl_pkg::FUNC_ORR;
			isa_pkg::LHI_OP: alu_func_code = ctrl_pkg::FUNC_ID2; // already shifted imm
			isa_pkg::BNE_OP, isa_pkg::BEQ_OP, isa_pkg::BGZ_OP, isa_pkg::BLZ_OP: begin
				alu_func_code = ctrl_pkg::FUNC_BXX;
				alu_branch_type = opcode[1:0];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	typedef logic [3:0] alu_func_t;
	typedef logic [1:0] branch_t;
	typedef logic [1:0] pc_src_t;
	typedef logic [1:0] reg_dest_t;
	typedef logic [1:0] reg_src_t;

	// codes 0..7 line up with the R-type function codes
	localparam alu_func_t FUNC_ADD  = 4'd0;
	localparam alu_func_t FUNC_SUB  = 4'd1;
	localparam alu_func_t FUNC_AND  = 4'd2;
	localparam alu_func_t FUNC_ORR  = 4'd3;
	localparam alu_func_t FUNC_NOT  = 4'd4;
	localparam alu_func_t FUNC_TCP  = 4'd5;
	localparam alu_func_t FUNC_SHL  = 4'd6;
	localparam alu_func_t FUNC_SHR  = 4'd7;
	localparam alu_func_t FUNC_ID1  = 4'd8;  // pass a
	localparam alu_func_t FUNC_ID2  = 4'd9;  // pass b
	localparam alu_func_t FUNC_BXX  = 4'd10; // branch compare
	localparam alu_func_t FUNC_NONE = 4'd15;

	localparam branch_t BR_NE = 2'd0;
	localparam branch_t BR_EQ = 2'd1;
	localparam branch_t BR_GZ = 2'd2;
	localparam branch_t BR_LZ = 2'd3;

	localparam pc_src_t PC_BRANCH = 2'd0; // pc+1, or branch target if taken
	localparam pc_src_t PC_JUMP   = 2'd1;
	localparam pc_src_t PC_REG    = 2'd2;

	localparam reg_dest_t DEST_RD   = 2'd0;
	localparam reg_dest_t DEST_RT   = 2'd1;
	localparam reg_dest_t DEST_LINK = 2'd2;

	localparam reg_src_t SRC_ALU = 2'd0;
	localparam reg_src_t SRC_MEM = 2'd1;
	localparam reg_src_t SRC_PC  = 2'd2;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0]  reg_idx_t;
	typedef logic [3:0]  opcode_t;
	typedef logic [5:0]  func_t;

	// opcodes, low two bits of branches give the branch type
	localparam opcode_t BNE_OP = 4'd0;
	localparam opcode_t BEQ_OP = 4'd1;
	localparam opcode_t BGZ_OP = 4'd2;
	localparam opcode_t BLZ_OP = 4'd3;
	localparam opcode_t ADI_OP = 4'd4;
	localparam opcode_t ORI_OP = 4'd5;
	localparam opcode_t LHI_OP = 4'd6;
	localparam opcode_t LWD_OP = 4'd7;
	localparam opcode_t SWD_OP = 4'd8;
	localparam opcode_t JMP_OP = 4'd9;
	localparam opcode_t JAL_OP = 4'd10;
	localparam opcode_t ALU_OP = 4'd15;

	// function codes under ALU_OP
	localparam func_t INST_FUNC_ADD = 6'd0;
	localparam func_t INST_FUNC_SUB = 6'd1;
	localparam func_t INST_FUNC_AND = 6'd2;
	localparam func_t INST_FUNC_ORR = 6'd3;
	localparam func_t INST_FUNC_NOT = 6'd4;
	localparam func_t INST_FUNC_TCP = 6'd5;
	localparam func_t INST_FUNC_SHL = 6'd6;
	localparam func_t INST_FUNC_SHR = 6'd7;
	localparam func_t INST_FUNC_JPR = 6'd25;
	localparam func_t INST_FUNC_JRL = 6'd26;
	localparam func_t INST_FUNC_WWD = 6'd28;
	localparam func_t INST_FUNC_HLT = 6'd29;

	localparam reg_idx_t LINK_REG = 2'd2; // JAL and JRL write here

	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		func_t    func;
	} r_fmt_t;

	typedef struct packed {
		opcode_t    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [7:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [11:0] target;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_t;

endpackage

`default_nettype wire
